/* flist.f */
src/sdram_map_pkg.sv
src/rom_request.sv
src/rom_bank_2slot.sv
src/ram_bank_rw.sv
src/sdram_slot_map.sv
dv/slot_checker.sv
dv/tb_sdram_slot_map.sv

/* run_sim.sh */
#!/bin/sh
# Builds the slot mapper testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_sdram_slot_map \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || { echo "No verdict found in sim.log"; exit 1; }
exit 0

/* dv/tb_sdram_slot_map.sv */
// Testbench for the slot mapper, runs the SDRAM bank model, stimulus and watchdog
`timescale 1ns/10ps

module tb_sdram_slot_map import sdram_map_pkg::*;;

    localparam int n_tests    = 5;
    localparam int test_limit = 16 * 2 * 14;      // Cycles, longest test worst case
    localparam int seed       = 43979;

    logic clk, rst, lvbl, rfsh_en, refresh_en;
    logic main_ram_cs, main_vram_cs, main_rnw, main_ram_ok;
    logic [1:0]             dsn, ba0_din_m;
    logic [15:0]            main_dout, main_ram_data, vram_dma_data, prog_data, ba0_din;
    logic [main_ram_aw-1:0] main_ram_addr, vram_dma_addr;
    logic                   vram_dma_cs, vram_dma_ok, snd_cs, snd_ok, gfx_cs, gfx_ok;
    logic [snd_aw-1:0]      snd_addr;
    logic [7:0]             snd_data;
    logic [gfx_aw-1:0]      gfx_addr;
    logic [31:0]            gfx_data;
    logic                   prog_cs, prog_ok;
    logic [prog_aw-1:0]     prog_addr;
    logic [sdram_aw-1:0]    ba0_addr, ba1_addr, ba3_addr;
    logic ba0_ack, ba0_rdy, ba0_rd, ba0_wr, ba1_ack, ba1_rdy, ba1_rd, ba3_ack, ba3_rdy, ba3_rd;
    logic [sdram_dw-1:0]    data_read;
    logic                   ack_v [4];
    logic                   rdy_v [4];
    logic [31:0]            bank_data [4];
    logic [15:0]            shadow0 [int];
    int unsigned            lcg_state = seed;
    int                     test_id, errors;
    logic                   test_done;

    assign {ba0_ack, ba1_ack, ba3_ack} = {ack_v[0], ack_v[1], ack_v[3]};
    assign {ba0_rdy, ba1_rdy, ba3_rdy} = {rdy_v[0], rdy_v[1], rdy_v[3]};
    assign data_read = rdy_v[1] ? bank_data[1] : rdy_v[3] ? bank_data[3] : bank_data[0];

    sdram_slot_map sdram_slot_map_i (.*);
    slot_checker   checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int next_rand(input int span);
        lcg_state = lcg_state * 1103515245 + 12345;
        return int'((lcg_state >> 8) % span);
    endfunction

    function automatic logic [15:0] rom_word(input int b, input logic [sdram_aw-1:0] a);
        return a[15:0] ^ {a[21:16], a[21:12]} ^ (16'h1357 * 16'(b + 1));
    endfunction

    function automatic logic [15:0] mem_word(input int b, input logic [sdram_aw-1:0] a);
        if (b == 0 && shadow0.exists(int'(a)))
            return shadow0[int'(a)];
        return rom_word(b, a);
    endfunction

    // One bank of the SDRAM, ack after 1 to 3 cycles, rdy 2 to 6 cycles later
    task automatic serve_bank(input int b);
        logic [sdram_aw-1:0] a;
        logic                wr;
        logic [15:0]         old;
        forever begin
            @(negedge clk);
            if (!rst && (b == 0 ? (ba0_rd || ba0_wr) : b == 1 ? ba1_rd : ba3_rd)) begin
                a  = b == 0 ? ba0_addr : b == 1 ? ba1_addr : ba3_addr;
                wr = b == 0 && ba0_wr;
                repeat (next_rand(3)) @(negedge clk);
                ack_v[b] = 1'b1;
                if (wr) begin
                    old = mem_word(0, a);
                    shadow0[int'(a)] = {ba0_din_m[1] ? old[15:8] : ba0_din[15:8],
                                        ba0_din_m[0] ? old[7:0]  : ba0_din[7:0]};
                end
                @(negedge clk);
                ack_v[b] = 1'b0;
                repeat (1 + next_rand(5)) @(negedge clk);
                bank_data[b] = {mem_word(b, a + 1), mem_word(b, a)};
                rdy_v[b] = 1'b1;
                @(negedge clk);
                rdy_v[b] = 1'b0;
            end
        end
    endtask

    initial serve_bank(0);
    initial serve_bank(1);
    initial serve_bank(3);

    task automatic prog_read(input logic [prog_aw-1:0] a);
        @(negedge clk);
        prog_cs   = 1'b1;
        prog_addr = a;
        @(negedge clk);
        while (!prog_ok) @(negedge clk);
        prog_cs = 1'b0;
    endtask

    // Sound and graphics together, until both have answered
    task automatic bank1_read(input logic [snd_aw-1:0] sa, input logic [gfx_aw-1:0] ga);
        logic snd_seen, gfx_seen;
        @(negedge clk);
        {snd_cs, gfx_cs, snd_addr, gfx_addr} = {2'b11, sa, ga};
        snd_seen = 1'b0;
        gfx_seen = 1'b0;
        while (!(snd_seen && gfx_seen)) begin
            @(negedge clk);
            snd_seen |= snd_ok;
            gfx_seen |= gfx_ok;
        end
        {snd_cs, gfx_cs} = 2'b00;
    endtask

    task automatic ram_access(input logic vram, input logic wr, input logic [main_ram_aw-1:0] a,
                              input logic [15:0] d, input logic [1:0] m);
        @(negedge clk);
        {main_ram_cs, main_vram_cs, main_rnw} = {!vram, vram, !wr};
        {main_ram_addr, main_dout, dsn} = {a, d, m};
        @(negedge clk);
        while (!main_ram_ok) @(negedge clk);
        {main_ram_cs, main_vram_cs, main_rnw} = 3'b001;
    endtask

    task automatic dma_read(input logic [main_ram_aw-1:0] a);
        @(negedge clk);
        vram_dma_cs   = 1'b1;
        vram_dma_addr = a;
        @(negedge clk);
        while (!vram_dma_ok) @(negedge clk);
        vram_dma_cs = 1'b0;
    endtask

    task automatic end_test;
        @(negedge clk);
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    initial begin
        #(n_tests * test_limit * 20 + 4000);
        $display("Watchdog expired, a slot never answered");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [prog_aw-1:0]     pa;
        logic [snd_aw-1:0]      sa;
        logic [gfx_aw-1:0]      ga;
        logic [main_ram_aw-1:0] ra;
        rst = 1'b1;
        {lvbl, rfsh_en, main_ram_cs, main_vram_cs, main_rnw, dsn, main_dout} = '0;
        {main_ram_addr, vram_dma_cs, vram_dma_addr, snd_cs, snd_addr} = '0;
        {gfx_cs, gfx_addr, prog_cs, prog_addr, test_id, test_done} = '0;
        main_rnw = 1'b1;
        lvbl     = 1'b1;
        for (int i = 0; i < 4; i++) begin
            ack_v[i] = 1'b0;
            rdy_v[i] = 1'b0;
            bank_data[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_id = 1;
        for (int i = 0; i < 8; i++) begin
            pa = prog_aw'(next_rand(1 << prog_aw));
            prog_read(pa);
        end
        end_test();
        test_id = 2;
        for (int i = 0; i < 6; i++) begin
            sa = snd_aw'(next_rand(1 << snd_aw));
            ga = gfx_aw'(next_rand(1 << gfx_aw));
            bank1_read(sa, ga);
        end
        end_test();
        test_id = 3;
        for (int m = 0; m < 4; m++) begin
            ra = main_ram_aw'(next_rand(1 << main_ram_aw));
            ram_access(1'b0, 1'b1, ra, 16'(next_rand(1 << 16)), 2'(m));
            ram_access(1'b0, 1'b0, ra, 16'h0, 2'b00);
            ram_access(1'b1, 1'b1, ra, 16'(next_rand(1 << 16)), 2'(m));
            ram_access(1'b1, 1'b0, ra, 16'h0, 2'b00);
            dma_read(ra);
        end
        end_test();
        test_id = 4;                              // Last addresses are still cached
        prog_read(pa);
        bank1_read(sa, ga);
        ram_access(1'b1, 1'b0, ra, 16'h0, 2'b00);
        dma_read(ra);
        end_test();
        test_id = 5;
        for (int i = 0; i < 24; i++) begin
            @(negedge clk);
            lvbl    = next_rand(2) != 0;
            rfsh_en = next_rand(2) != 0;
        end
        end_test();
        repeat (4) @(negedge clk);
        $display("Tests run %0d, errors %0d", n_tests, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* dv/slot_checker.sv */
// Watches the slot mapper ports, predicts each slot's data and reports mismatches per test
`timescale 1ns/10ps

module slot_checker import sdram_map_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   lvbl,
    input  logic                   rfsh_en,
    input  logic                   refresh_en,
    input  logic                   main_vram_cs,
    input  logic                   main_rnw,
    input  logic [main_ram_aw-1:0] main_ram_addr,
    input  logic [15:0]            main_dout,
    input  logic [1:0]             dsn,
    input  logic                   main_ram_ok,
    input  logic [15:0]            main_ram_data,
    input  logic [main_ram_aw-1:0] vram_dma_addr,
    input  logic                   vram_dma_ok,
    input  logic [15:0]            vram_dma_data,
    input  logic [snd_aw-1:0]      snd_addr,
    input  logic                   snd_ok,
    input  logic [7:0]             snd_data,
    input  logic [gfx_aw-1:0]      gfx_addr,
    input  logic                   gfx_ok,
    input  logic [31:0]            gfx_data,
    input  logic [prog_aw-1:0]     prog_addr,
    input  logic                   prog_ok,
    input  logic [15:0]            prog_data,
    input  logic [sdram_aw-1:0]    ba0_addr,
    input  logic                   ba0_rd,
    input  logic                   ba0_wr,
    input  logic [15:0]            ba0_din,
    input  logic [1:0]             ba0_din_m,
    input  logic                   ba0_ack,
    input  logic                   ba0_rdy,
    input  logic                   ba1_rd,
    input  logic                   ba1_ack,
    input  logic                   ba1_rdy,
    input  logic                   ba3_rd,
    input  logic                   ba3_ack,
    input  logic                   ba3_rdy,
    input  int                     test_id,
    input  logic                   test_done,
    output int                     errors
);

    logic [15:0]            shadow0 [int];   // Bank 0 words written so far
    logic [main_ram_aw-1:0] ram_h, dma_h;
    logic                   vram_h, rnw_h;
    logic [15:0]            dout_h;
    logic [1:0]             dsn_h;
    logic [snd_aw-1:0]      snd_h1, snd_h2;  // Sound output lags two edges
    logic [gfx_aw-1:0]      gfx_h;
    logic [prog_aw-1:0]     prog_h;
    logic                   lvbl_h, rfsh_h, hist_valid, reset_checked;
    logic [2:0]             rd_h, in_flight, rd_now, ack_now, rdy_now;
    int                     base_errors = 0;

    initial errors = 0;

    // Same pattern as the bank model and unique for every address bit
    function automatic logic [15:0] rom_word(input int b, input logic [sdram_aw-1:0] a);
        return a[15:0] ^ {a[21:16], a[21:12]} ^ (16'h1357 * 16'(b + 1));
    endfunction

    function automatic logic [15:0] ram_word(input logic [sdram_aw-1:0] a);
        if (shadow0.exists(int'(a)))
            return shadow0[int'(a)];
        return rom_word(0, a);
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic flag_error(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    always @(posedge clk) begin
        logic [sdram_aw-1:0] a;
        logic [15:0]         w;
        if (rst) begin
            hist_valid    = 1'b0;
            reset_checked = 1'b0;
            in_flight     = '0;
            rd_h          = '0;
        end else begin
            if (!reset_checked) begin
                if ({ba0_rd, ba0_wr, ba1_rd, ba3_rd, main_ram_ok, vram_dma_ok,
                     snd_ok, gfx_ok, prog_ok, refresh_en} !== '0)
                    flag_error("an rd, wr, ok or refresh_en output is high after reset");
                reset_checked = 1'b1;
            end
            if (hist_valid) begin
                compare("refresh_en", 32'(!lvbl_h && rfsh_h), 32'(refresh_en));
                if (prog_ok)
                    compare("prog_data", 32'(rom_word(3, prog_offset + 22'(prog_h))), 32'(prog_data));
                if (gfx_ok) begin
                    a = gfx_offset + 22'(gfx_h);
                    compare("gfx_data", {rom_word(1, a + 1), rom_word(1, a)}, gfx_data);
                end
                if (snd_ok) begin
                    w = rom_word(1, snd_offset + 22'(snd_h2[snd_aw-1:1]));
                    compare("snd_data", 32'(snd_h2[0] ? w[15:8] : w[7:0]), 32'(snd_data));
                end
                if (main_ram_ok && rnw_h) begin
                    a = (vram_h ? vram_offset : ram_offset) + 22'(ram_h);
                    compare("main_ram_data", 32'(ram_word(a)), 32'(main_ram_data));
                end
                // Completed CPU write, merged under the active low byte mask
                if (main_ram_ok && !rnw_h) begin
                    a = (vram_h ? vram_offset : ram_offset) + 22'(ram_h);
                    w = ram_word(a);
                    shadow0[int'(a)] = {dsn_h[1] ? w[15:8] : dout_h[15:8],
                                        dsn_h[0] ? w[7:0]  : dout_h[7:0]};
                end
                if (vram_dma_ok)
                    compare("vram_dma_data", 32'(ram_word(vram_offset + 22'(dma_h))),
                            32'(vram_dma_data));
            end
            if (ba0_wr && ba0_ack) begin
                a = (main_vram_cs ? vram_offset : ram_offset) + 22'(main_ram_addr);
                compare("ba0_addr", 32'(a), 32'(ba0_addr));
                compare("ba0_din", 32'(main_dout), 32'(ba0_din));
                compare("ba0_din_m", 32'(dsn), 32'(ba0_din_m));
            end
            rd_now  = {ba3_rd, ba1_rd, ba0_rd || ba0_wr};
            ack_now = {ba3_ack, ba1_ack, ba0_ack};
            rdy_now = {ba3_rdy, ba1_rdy, ba0_rdy};
            for (int i = 0; i < 3; i++) begin
                if (rd_now[i] && in_flight[i])
                    flag_error($sformatf("bank slot %0d requests while an access is in flight", i));
                if (ack_now[i])
                    in_flight[i] = 1'b1;
                else if (rdy_now[i])
                    in_flight[i] = 1'b0;
            end
            if (test_id == 4 && (rd_now & ~rd_h) != 0)
                flag_error("a bank access started during the cache hit test");
            rd_h   = rd_now;
            ram_h  = main_ram_addr;
            vram_h = main_vram_cs;
            rnw_h  = main_rnw;
            dout_h = main_dout;
            dsn_h  = dsn;
            dma_h  = vram_dma_addr;
            snd_h2 = snd_h1;
            snd_h1 = snd_addr;
            gfx_h  = gfx_addr;
            prog_h = prog_addr;
            lvbl_h = lvbl;
            rfsh_h = rfsh_en;
            hist_valid = 1'b1;
        end
        if (test_done) begin
            $display("Test %0d done, %0d errors", test_id, errors - base_errors);
            base_errors = errors;
        end
    end

endmodule

/* src/sdram_slot_map.sv */
// Top of the slot mapper, connects CPU, sound, graphics and DMA clients to SDRAM banks 0, 1 and 3
`timescale 1ns/10ps

module sdram_slot_map import sdram_map_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   lvbl,
    input  logic                   rfsh_en,
    // Main CPU RAM and VRAM
    input  logic                   main_ram_cs,
    input  logic                   main_vram_cs,
    input  logic                   main_rnw,
    input  logic [1:0]             dsn,
    input  logic [15:0]            main_dout,
    input  logic [main_ram_aw-1:0] main_ram_addr,
    output logic                   main_ram_ok,
    output logic [15:0]            main_ram_data,
    // Video DMA
    input  logic                   vram_dma_cs,
    input  logic [main_ram_aw-1:0] vram_dma_addr,
    output logic                   vram_dma_ok,
    output logic [15:0]            vram_dma_data,
    // Sound CPU
    input  logic                   snd_cs,
    input  logic [snd_aw-1:0]      snd_addr,
    output logic                   snd_ok,
    output logic [7:0]             snd_data,
    // Graphics
    input  logic                   gfx_cs,
    input  logic [gfx_aw-1:0]      gfx_addr,
    output logic                   gfx_ok,
    output logic [31:0]            gfx_data,
    // Main CPU program
    input  logic                   prog_cs,
    input  logic [prog_aw-1:0]     prog_addr,
    output logic                   prog_ok,
    output logic [15:0]            prog_data,
    // Bank 0
    input  logic                   ba0_ack,
    input  logic                   ba0_rdy,
    output logic [sdram_aw-1:0]    ba0_addr,
    output logic                   ba0_rd,
    output logic                   ba0_wr,
    output logic [15:0]            ba0_din,
    output logic [1:0]             ba0_din_m,
    // Bank 1
    input  logic                   ba1_ack,
    input  logic                   ba1_rdy,
    output logic [sdram_aw-1:0]    ba1_addr,
    output logic                   ba1_rd,
    // Bank 3
    input  logic                   ba3_ack,
    input  logic                   ba3_rdy,
    output logic [sdram_aw-1:0]    ba3_addr,
    output logic                   ba3_rd,
    input  logic [sdram_dw-1:0]    data_read,
    output logic                   refresh_en
);

    logic                ram_cs;
    logic [sdram_aw-1:0] main_offset;
    logic [7:0]          pre_snd_data;
    logic                pre_snd_ok;

    assign ram_cs      = main_ram_cs | main_vram_cs;
    assign main_offset = main_vram_cs ? vram_offset : ram_offset;

    // Refresh only during vertical blank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            refresh_en <= 1'b0;
            snd_ok     <= 1'b0;
        end else begin
            refresh_en <= !lvbl && rfsh_en;
            snd_ok     <= pre_snd_ok;
        end
    end

    always_ff @(posedge clk)
        snd_data <= pre_snd_data;          // Aligned with snd_ok

    ram_bank_rw u_bank0 (
        .clk          ( clk           ),
        .rst          ( rst           ),
        .slot0_cs     ( ram_cs        ),
        .slot0_wen    ( !main_rnw     ),
        .slot0_addr   ( main_ram_addr ),
        .slot0_din    ( main_dout     ),
        .slot0_wrmask ( dsn           ),
        .offset0      ( main_offset   ),
        .slot1_cs     ( vram_dma_cs   ),
        .slot1_addr   ( vram_dma_addr ),
        .ack          ( ba0_ack       ),
        .rdy          ( ba0_rdy       ),
        .data_read    ( data_read     ),
        .slot0_ok     ( main_ram_ok   ),
        .slot0_dout   ( main_ram_data ),
        .slot1_ok     ( vram_dma_ok   ),
        .slot1_dout   ( vram_dma_data ),
        .sdram_addr   ( ba0_addr      ),
        .sdram_rd     ( ba0_rd        ),
        .sdram_wr     ( ba0_wr        ),
        .sdram_din    ( ba0_din       ),
        .sdram_wrmask ( ba0_din_m     )
    );

    // Sound code and graphics share bank 1
    rom_bank_2slot #(
        .slot0_t ( logic [7:0]  ),
        .slot1_t ( logic [31:0] ),
        .aw0     ( snd_aw       ),
        .aw1     ( gfx_aw       )
    ) u_bank1 (
        .clk        ( clk          ),
        .rst        ( rst          ),
        .slot0_cs   ( snd_cs       ),
        .slot1_cs   ( gfx_cs       ),
        .slot0_addr ( snd_addr     ),
        .slot1_addr ( gfx_addr     ),
        .offset0    ( snd_offset   ),
        .offset1    ( gfx_offset   ),
        .ack        ( ba1_ack      ),
        .rdy        ( ba1_rdy      ),
        .data_read  ( data_read    ),
        .slot0_ok   ( pre_snd_ok   ),
        .slot1_ok   ( gfx_ok       ),
        .slot0_dout ( pre_snd_data ),
        .slot1_dout ( gfx_data     ),
        .sdram_addr ( ba1_addr     ),
        .sdram_rd   ( ba1_rd       )
    );

    rom_request #(.data_t(logic [15:0]), .aw(prog_aw)) u_bank3 (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .cs         ( prog_cs     ),
        .addr       ( prog_addr   ),
        .offset     ( prog_offset ),
        .grant      ( 1'b1        ),  // Sole client of bank 3
        .ack        ( ba3_ack     ),
        .rdy        ( ba3_rdy     ),
        .data_read  ( data_read   ),
        .req        ( ba3_rd      ),
        .sdram_addr ( ba3_addr    ),
        .dout       ( prog_data   ),
        .ok         ( prog_ok     )
    );

endmodule

/* src/ram_bank_rw.sv */
// Bank 0 controller, CPU RAM read/write slot plus read-only video DMA slot
`timescale 1ns/10ps

module ram_bank_rw import sdram_map_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   slot0_cs,
    input  logic                   slot0_wen,
    input  logic [main_ram_aw-1:0] slot0_addr,
    input  logic [15:0]            slot0_din,
    input  logic [1:0]             slot0_wrmask,   // Active low byte enables
    input  logic [sdram_aw-1:0]    offset0,
    input  logic                   slot1_cs,
    input  logic [main_ram_aw-1:0] slot1_addr,
    input  logic                   ack,
    input  logic                   rdy,
    input  logic [sdram_dw-1:0]    data_read,
    output logic                   slot0_ok,
    output logic [15:0]            slot0_dout,
    output logic                   slot1_ok,
    output logic [15:0]            slot1_dout,
    output logic [sdram_aw-1:0]    sdram_addr,
    output logic                   sdram_rd,
    output logic                   sdram_wr,
    output logic [15:0]            sdram_din,
    output logic [1:0]             sdram_wrmask
);

    typedef enum logic [1:0] {st_idle, st_wait_ack, st_wait_rdy} state_t;

    state_t              state;
    logic                cur_slot;
    logic                cur_wr;
    logic                wdone;            // Write finished, cs still up
    logic                valid0, valid1;
    logic [sdram_aw-1:0] cached0, cached1; // Full bank address as cache key
    logic [15:0]         data0, data1;
    logic [sdram_aw-1:0] key0, key1;
    logic                hit0, hit1;
    logic                need0, need1;
    logic                load0, load1, wr_end;

    assign key0 = offset0 + sdram_aw'(slot0_addr);
    assign key1 = vram_offset + sdram_aw'(slot1_addr);
    assign hit0 = valid0 && cached0 == key0;
    assign hit1 = valid1 && cached1 == key1;

    assign need0  = slot0_cs && (slot0_wen ? !wdone : !hit0);
    assign need1  = slot1_cs && !hit1;
    assign load0  = state == st_wait_rdy && rdy && !cur_wr && !cur_slot;
    assign load1  = state == st_wait_rdy && rdy && cur_slot;
    assign wr_end = state == st_wait_rdy && rdy && cur_wr;

    assign slot0_dout = data0;
    assign slot1_dout = data1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            cur_slot <= 1'b0;
            cur_wr   <= 1'b0;
            sdram_rd <= 1'b0;
            sdram_wr <= 1'b0;
            valid0   <= 1'b0;
            valid1   <= 1'b0;
            wdone    <= 1'b0;
            slot0_ok <= 1'b0;
            slot1_ok <= 1'b0;
        end else begin
            slot0_ok <= slot0_cs && (slot0_wen ? (wdone || wr_end) : (hit0 && !load0));
            slot1_ok <= slot1_cs && hit1 && !load1;
            if (!(slot0_cs && slot0_wen))
                wdone <= 1'b0;
            else if (wr_end)
                wdone <= 1'b1;
            case (state)
                st_idle: begin
                    if (need0) begin
                        state    <= st_wait_ack;
                        cur_slot <= 1'b0;
                        cur_wr   <= slot0_wen;
                        sdram_rd <= !slot0_wen;
                        sdram_wr <= slot0_wen;
                        if (slot0_wen) begin
                            valid0 <= 1'b0;
                            valid1 <= 1'b0;  // DMA may read the written region
                        end
                    end else if (need1) begin
                        state    <= st_wait_ack;
                        cur_slot <= 1'b1;
                        cur_wr   <= 1'b0;
                        sdram_rd <= 1'b1;
                    end
                end
                st_wait_ack: if (ack) begin
                    sdram_rd <= 1'b0;
                    sdram_wr <= 1'b0;
                    state    <= st_wait_rdy;
                end
                default: if (rdy) begin
                    state <= st_idle;
                    if (load0)
                        valid0 <= 1'b1;
                    if (load1)
                        valid1 <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            sdram_addr   <= need0 ? key0 : key1;
            sdram_din    <= slot0_din;
            sdram_wrmask <= slot0_wrmask;
        end
        if (load0) begin
            cached0 <= sdram_addr;
            data0   <= data_read[15:0];
        end
        if (load1) begin
            cached1 <= sdram_addr;
            data1   <= data_read[15:0];
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(sdram_rd && sdram_wr));

endmodule

/* src/rom_bank_2slot.sv */
// Two cached read-only slots sharing one SDRAM bank, slot0 has priority
`timescale 1ns/10ps

module rom_bank_2slot import sdram_map_pkg::*; #(
    parameter type slot0_t = logic [7:0],
    parameter type slot1_t = logic [31:0],
    parameter int  aw0     = 16,
    parameter int  aw1     = 20
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                slot0_cs,
    input  logic                slot1_cs,
    input  logic [aw0-1:0]      slot0_addr,
    input  logic [aw1-1:0]      slot1_addr,
    input  logic [sdram_aw-1:0] offset0,
    input  logic [sdram_aw-1:0] offset1,
    input  logic                ack,
    input  logic                rdy,
    input  logic [sdram_dw-1:0] data_read,
    output logic                slot0_ok,
    output logic                slot1_ok,
    output slot0_t              slot0_dout,
    output slot1_t              slot1_dout,
    output logic [sdram_aw-1:0] sdram_addr,
    output logic                sdram_rd
);

    logic                req0;
    logic                req1;
    logic [sdram_aw-1:0] addr0;
    logic [sdram_aw-1:0] addr1;
    logic                locked;           // Bank owned until rdy
    logic                owner;
    logic                sel;

    // Free bank goes to slot0 first
    assign sel = locked ? owner : (!req0 && req1);

    assign sdram_rd   = sel ? req1 : req0;
    assign sdram_addr = sel ? addr1 : addr0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= 1'b0;
        end else if (locked) begin
            if (rdy)
                locked <= 1'b0;
        end else if (req0 || req1) begin
            locked <= 1'b1;
            owner  <= !req0;
        end
    end

    rom_request #(.data_t(slot0_t), .aw(aw0)) u_slot0 (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cs         ( slot0_cs   ),
        .addr       ( slot0_addr ),
        .offset     ( offset0    ),
        .grant      ( !sel       ),
        .ack        ( ack        ),
        .rdy        ( rdy        ),
        .data_read  ( data_read  ),
        .req        ( req0       ),
        .sdram_addr ( addr0      ),
        .dout       ( slot0_dout ),
        .ok         ( slot0_ok   )
    );

    rom_request #(.data_t(slot1_t), .aw(aw1)) u_slot1 (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cs         ( slot1_cs   ),
        .addr       ( slot1_addr ),
        .offset     ( offset1    ),
        .grant      ( sel        ),
        .ack        ( ack        ),
        .rdy        ( rdy        ),
        .data_read  ( data_read  ),
        .req        ( req1       ),
        .sdram_addr ( addr1      ),
        .dout       ( slot1_dout ),
        .ok         ( slot1_ok   )
    );

    // The acked slot keeps the bank until its data returns
    a_owner_held: assert property (@(posedge clk) disable iff (rst)
        ack |=> locked && owner == $past(sel));

endmodule

/* src/rom_request.sv */
// Read-only SDRAM slot with a last-word cache; used alone or inside a shared bank
`timescale 1ns/10ps

module rom_request import sdram_map_pkg::*; #(
    parameter type data_t = logic [15:0],
    parameter int  aw     = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cs,
    input  logic [aw-1:0]       addr,
    input  logic [sdram_aw-1:0] offset,
    input  logic                grant,      // Bank currently serves this slot
    input  logic                ack,
    input  logic                rdy,
    input  logic [sdram_dw-1:0] data_read,
    output logic                req,
    output logic [sdram_aw-1:0] sdram_addr,
    output data_t               dout,
    output logic                ok
);

    localparam int dw = $bits(data_t);

    logic [aw-1:0]       cached_addr;
    logic [aw-1:0]       pend_addr;        // Address of the access in flight
    logic                valid;
    logic                busy;             // Acked, waiting for rdy
    logic                hit;
    logic                start;
    logic                load;
    logic [sdram_aw-1:0] word_addr;
    data_t               fetched;

    assign hit   = valid && cached_addr == addr;
    assign start = cs && !hit && !req && !busy;
    assign load  = busy && rdy;

    // Byte slots address half words
    assign word_addr  = (dw == 8) ? sdram_aw'(pend_addr[aw-1:1]) : sdram_aw'(pend_addr);
    assign sdram_addr = offset + word_addr;

    always_comb begin
        if (dw == 8)
            fetched = data_t'(pend_addr[0] ? data_read[15:8] : data_read[7:0]);
        else
            fetched = data_t'(data_read[dw-1:0]);  // Low word first
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req   <= 1'b0;
            busy  <= 1'b0;
            valid <= 1'b0;
            ok    <= 1'b0;
        end else begin
            ok <= cs && hit && !load;          // Held low while the cache reloads
            if (load) begin
                busy  <= 1'b0;
                valid <= 1'b1;
            end else if (req && ack && grant) begin
                req  <= 1'b0;
                busy <= 1'b1;
            end else if (start) begin
                req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            pend_addr <= addr;
        if (load) begin
            cached_addr <= pend_addr;
            dout        <= fetched;
        end
    end

    // A new fetch only starts on a miss, so ok is already low
    a_req_not_on_ok: assert property (@(posedge clk) disable iff (rst)
        $rose(req) |-> !ok);

    a_dout_stable: assert property (@(posedge clk) disable iff (rst)
        ok && $past(ok) |-> $stable(dout));

endmodule

/* src/sdram_map_pkg.sv */
// Widths and bank offsets shared by the slot mapper modules, imported where needed
package sdram_map_pkg;

    // SDRAM side
    localparam int sdram_aw = 22;           // Word address per bank
    localparam int sdram_dw = 32;           // Two consecutive words per read

    // Bank 0, read/write
    localparam logic [sdram_aw-1:0] ram_offset  = 22'h00_0000;
    localparam logic [sdram_aw-1:0] vram_offset = 22'h10_0000;

    // Bank 1, sound code and graphics
    localparam logic [sdram_aw-1:0] snd_offset  = 22'h00_0000;
    localparam logic [sdram_aw-1:0] gfx_offset  = 22'h20_0000;

    // Bank 3, main CPU program
    localparam logic [sdram_aw-1:0] prog_offset = 22'h00_0000;

    // Slot address widths
    localparam int main_ram_aw = 17;        // Words, RAM and DMA slots
    localparam int snd_aw      = 16;        // Bytes
    localparam int gfx_aw      = 20;        // Words
    localparam int prog_aw     = 21;        // Words

endpackage
